/* verilog/lsu_pkg.sv */
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;
    // one strobe per byte lane
    localparam int STRB_W = XLEN / 8;
    // destination register tag
    localparam int REG_ADDR_W = 5;
    // operation word width, both union views
    localparam int OP_W = 7;

    // operation kinds
    localparam logic [2:0] KIND_LOAD  = 3'd0;
    localparam logic [2:0] KIND_STORE = 3'd1;
    localparam logic [2:0] KIND_LR    = 3'd2;
    localparam logic [2:0] KIND_SC    = 3'd3;
    localparam logic [2:0] KIND_AMO   = 3'd4;

    // access sizes for ordinary loads and stores
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // amo functions
    localparam logic [3:0] AMO_SWAP = 4'd0;
    localparam logic [3:0] AMO_ADD  = 4'd1;
    localparam logic [3:0] AMO_XOR  = 4'd2;
    localparam logic [3:0] AMO_AND  = 4'd3;
    localparam logic [3:0] AMO_OR   = 4'd4;
    localparam logic [3:0] AMO_MIN  = 4'd5;
    localparam logic [3:0] AMO_MAX  = 4'd6;
    localparam logic [3:0] AMO_MINU = 4'd7;
    localparam logic [3:0] AMO_MAXU = 4'd8;

    // load/store view
    typedef struct packed {
        logic [2:0] kind;
        logic       unsign;
        logic [1:0] size;
        logic       rsvd;
    } lsu_ldst_t;

    // atomic view, always word sized
    typedef struct packed {
        logic [2:0] kind;
        logic [3:0] func;
    } lsu_amo_t;

    // kind sits in the same bits in both views
    typedef union packed {
        lsu_ldst_t ldst;
        lsu_amo_t  amo;
    } lsu_op_u;

endpackage

/* verilog/lsu_req_queue.sv */
module lsu_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push_i,
    input  lsu_pkg::lsu_op_u                  op_i,
    input  logic [lsu_pkg::XLEN-1:0]          addr_i,
    input  logic [lsu_pkg::XLEN-1:0]          data_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]    rd_i,
    input  logic                              pop_i,
    output logic                              head_valid_o,
    output lsu_pkg::lsu_op_u                  head_op_o,
    output logic [lsu_pkg::XLEN-1:0]          head_addr_o,
    output logic [lsu_pkg::XLEN-1:0]          head_data_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    head_rd_o,
    output logic                              credit_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // entry storage
    logic [lsu_pkg::OP_W-1:0]       op_mem   [QUEUE_DEPTH];
    logic [lsu_pkg::XLEN-1:0]       addr_mem [QUEUE_DEPTH];
    logic [lsu_pkg::XLEN-1:0]       data_mem [QUEUE_DEPTH];
    logic [lsu_pkg::REG_ADDR_W-1:0] rd_mem   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             credit_q;

    always_ff @(posedge clk) begin
        if (push_i) begin
            op_mem[wr_ptr_q]   <= op_i;
            addr_mem[wr_ptr_q] <= addr_i;
            data_mem[wr_ptr_q] <= data_i;
            rd_mem[wr_ptr_q]   <= rd_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            // explicit wrap, depth need not be a power of two
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // one credit back per retired entry
            credit_q <= pop_i;
        end
    end

    assign head_valid_o = (count_q != '0);
    assign head_op_o    = op_mem[rd_ptr_q];
    assign head_addr_o  = addr_mem[rd_ptr_q];
    assign head_data_o  = data_mem[rd_ptr_q];
    assign head_rd_o    = rd_mem[rd_ptr_q];
    assign credit_o     = credit_q;

    // upstream spent a credit it did not hold
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push_i |-> (count_q < CNT_W'(QUEUE_DEPTH)));

    // control retired an entry that was never queued
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop_i |-> (count_q != '0));

endmodule

/* verilog/lsu_ctrl.sv */
module lsu_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              head_valid_i,
    input  lsu_pkg::lsu_op_u                  head_op_i,
    input  logic [lsu_pkg::XLEN-1:0]          head_addr_i,
    input  logic [lsu_pkg::XLEN-1:0]          head_data_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]    head_rd_i,
    input  logic                              mem_ack_i,
    input  logic [lsu_pkg::XLEN-1:0]          mem_rdata_i,
    input  logic [lsu_pkg::STRB_W-1:0]        store_wstrb_i,
    input  logic [lsu_pkg::XLEN-1:0]          store_wdata_i,
    input  logic [lsu_pkg::XLEN-1:0]          load_data_i,
    input  logic [lsu_pkg::XLEN-1:0]          amo_new_i,
    output logic                              pop_o,
    output logic [lsu_pkg::XLEN-1:0]          old_word_o,
    output logic                              mem_req_o,
    output logic                              mem_we_o,
    output logic [lsu_pkg::XLEN-1:0]          mem_addr_o,
    output logic [lsu_pkg::STRB_W-1:0]        mem_wstrb_o,
    output logic [lsu_pkg::XLEN-1:0]          mem_wdata_o,
    output logic                              rsp_valid_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    rsp_rd_o,
    output logic [lsu_pkg::XLEN-1:0]          rsp_data_o,
    output logic                              rsp_fault_o
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam logic [1:0] ST_RESP  = 2'd3;

    logic [1:0]                     state_q;
    logic [1:0]                     state_d;
    logic [lsu_pkg::XLEN-1:0]       old_q;
    logic [lsu_pkg::XLEN-1:0]       new_q;
    logic                           resv_valid_q;
    logic [lsu_pkg::XLEN-3:0]       resv_addr_q;
    logic [lsu_pkg::XLEN-1:0]       rsp_data_d;
    logic [lsu_pkg::XLEN-1:0]       rsp_data_q;
    logic [lsu_pkg::REG_ADDR_W-1:0] rsp_rd_q;
    logic                           rsp_fault_q;

    // kind decode, same bits in both views
    logic is_load;
    logic is_store;
    logic is_lr;
    logic is_sc;
    logic is_amo;
    logic misaligned;
    logic sc_ok;
    logic skip_mem;
    logic start;
    logic read_done;
    logic write_done;

    assign is_load  = (head_op_i.ldst.kind == lsu_pkg::KIND_LOAD);
    assign is_store = (head_op_i.ldst.kind == lsu_pkg::KIND_STORE);
    assign is_lr    = (head_op_i.ldst.kind == lsu_pkg::KIND_LR);
    assign is_sc    = (head_op_i.ldst.kind == lsu_pkg::KIND_SC);
    assign is_amo   = (head_op_i.amo.kind == lsu_pkg::KIND_AMO);

    // atomics must be word aligned
    assign misaligned = (is_lr || is_sc || is_amo) && (head_addr_i[1:0] != 2'b00);
    // sc only hits a live reservation on the same word
    assign sc_ok    = is_sc && resv_valid_q && (resv_addr_q == head_addr_i[lsu_pkg::XLEN-1:2]);
    // resolved without touching memory
    assign skip_mem = misaligned || (is_sc && !sc_ok);

    assign start      = (state_q == ST_IDLE) && head_valid_i;
    assign read_done  = (state_q == ST_READ) && mem_ack_i;
    assign write_done = (state_q == ST_WRITE) && mem_ack_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (head_valid_i) begin
                    if (skip_mem) begin
                        state_d = ST_RESP;
                    end else if (is_store || is_sc) begin
                        state_d = ST_WRITE;
                    end else begin
                        state_d = ST_READ;
                    end
                end
            end
            // amo goes on to write back the new value
            ST_READ: begin
                if (mem_ack_i) begin
                    state_d = is_amo ? ST_WRITE : ST_RESP;
                end
            end
            ST_WRITE: begin
                if (mem_ack_i) begin
                    state_d = ST_RESP;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // entry retires one cycle before its response
    assign pop_o = (start && skip_mem) || (read_done && !is_amo) || write_done;

    always_comb begin
        rsp_data_d = '0;
        if (state_q == ST_IDLE) begin
            // failed sc returns 1, faults return 0
            rsp_data_d = misaligned ? '0 : lsu_pkg::XLEN'(1);
        end else if (state_q == ST_READ) begin
            rsp_data_d = is_load ? load_data_i : mem_rdata_i;
        end else if (is_amo) begin
            rsp_data_d = old_q;
        end
    end

    always_ff @(posedge clk) begin
        if (read_done) begin
            old_q <= mem_rdata_i;
            new_q <= amo_new_i;
        end
        if (read_done && is_lr) begin
            resv_addr_q <= head_addr_i[lsu_pkg::XLEN-1:2];
        end
        if (pop_o) begin
            rsp_data_q  <= rsp_data_d;
            rsp_rd_q    <= head_rd_i;
            rsp_fault_q <= misaligned;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            resv_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // sc, amo and plain stores drop the reservation
            if (start && (is_sc || is_amo || is_store)) begin
                resv_valid_q <= 1'b0;
            end else if (read_done && is_lr) begin
                resv_valid_q <= 1'b1;
            end
        end
    end

    // alu sees the word as it arrives
    assign old_word_o = (state_q == ST_READ) ? mem_rdata_i : old_q;

    assign mem_req_o  = (state_q == ST_READ) || (state_q == ST_WRITE);
    assign mem_we_o   = (state_q == ST_WRITE);
    assign mem_addr_o = {head_addr_i[lsu_pkg::XLEN-1:2], 2'b00};
    // atomics write the whole word
    assign mem_wstrb_o = !mem_we_o ? '0 : (is_store ? store_wstrb_i : '1);
    assign mem_wdata_o = !mem_we_o ? '0 :
                         is_amo    ? new_q :
                         is_sc     ? head_data_i : store_wdata_i;

    assign rsp_valid_o = (state_q == ST_RESP);
    assign rsp_rd_o    = rsp_rd_q;
    assign rsp_data_o  = rsp_data_q;
    assign rsp_fault_o = rsp_fault_q;

    // queue head must not move under an open request
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_we_o) &&
        $stable(mem_addr_o) && $stable(mem_wstrb_o) && $stable(mem_wdata_o)));

endmodule

/* verilog/lsu_store_align.sv */
module lsu_store_align (
    input  lsu_pkg::lsu_op_u                 op_i,
    input  logic [1:0]                       offset_i,
    input  logic [lsu_pkg::XLEN-1:0]         data_i,
    output logic [lsu_pkg::STRB_W-1:0]       wstrb_o,
    output logic [lsu_pkg::XLEN-1:0]         wdata_o
);

    logic [lsu_pkg::STRB_W-1:0] size_mask;

    // lanes covered at offset zero
    always_comb begin
        case (op_i.ldst.size)
            lsu_pkg::SIZE_BYTE: size_mask = lsu_pkg::STRB_W'(4'b0001);
            lsu_pkg::SIZE_HALF: size_mask = lsu_pkg::STRB_W'(4'b0011);
            default:            size_mask = '1;
        endcase
    end

    // natural alignment keeps the mask inside the word
    assign wstrb_o = size_mask << offset_i;
    // move low bytes of rs2 up to the addressed lanes
    assign wdata_o = data_i << {offset_i, 3'b000};

endmodule

/* verilog/lsu_load_extract.sv */
module lsu_load_extract (
    input  lsu_pkg::lsu_op_u                 op_i,
    input  logic [1:0]                       offset_i,
    input  logic [lsu_pkg::XLEN-1:0]         rdata_i,
    output logic [lsu_pkg::XLEN-1:0]         data_o
);

    logic [lsu_pkg::XLEN-1:0] shifted;
    logic                     byte_sign;
    logic                     half_sign;

    // addressed byte down to lane zero
    assign shifted = rdata_i >> {offset_i, 3'b000};

    // sign bit, or zero for the unsigned forms
    assign byte_sign = shifted[7] && !op_i.ldst.unsign;
    assign half_sign = shifted[15] && !op_i.ldst.unsign;

    always_comb begin
        case (op_i.ldst.size)
            lsu_pkg::SIZE_BYTE: begin
                data_o = {{(lsu_pkg::XLEN - 8){byte_sign}}, shifted[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                data_o = {{(lsu_pkg::XLEN - 16){half_sign}}, shifted[15:0]};
            end
            // word, offset is zero here
            default: begin
                data_o = shifted;
            end
        endcase
    end

endmodule

/* verilog/lsu_amo_alu.sv */
module lsu_amo_alu (
    input  logic [3:0]                       func_i,
    input  logic [lsu_pkg::XLEN-1:0]         old_i,
    input  logic [lsu_pkg::XLEN-1:0]         operand_i,
    output logic [lsu_pkg::XLEN-1:0]         new_o
);

    logic lt_signed;
    logic lt_unsigned;

    // old below rs2
    assign lt_signed   = $signed(old_i) < $signed(operand_i);
    assign lt_unsigned = old_i < operand_i;

    always_comb begin
        case (func_i)
            lsu_pkg::AMO_SWAP: new_o = operand_i;
            lsu_pkg::AMO_ADD:  new_o = old_i + operand_i;
            lsu_pkg::AMO_XOR:  new_o = old_i ^ operand_i;
            lsu_pkg::AMO_AND:  new_o = old_i & operand_i;
            lsu_pkg::AMO_OR:   new_o = old_i | operand_i;
            lsu_pkg::AMO_MIN:  new_o = lt_signed ? old_i : operand_i;
            lsu_pkg::AMO_MAX:  new_o = lt_signed ? operand_i : old_i;
            lsu_pkg::AMO_MINU: new_o = lt_unsigned ? old_i : operand_i;
            lsu_pkg::AMO_MAXU: new_o = lt_unsigned ? operand_i : old_i;
            // unknown codes behave as swap
            default:           new_o = operand_i;
        endcase
    end

endmodule

/* verilog/lsu_top.sv */
module lsu_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    // pipeline side, credit based
    input  logic                              req_valid_i,
    input  lsu_pkg::lsu_op_u                  req_op_i,
    input  logic [lsu_pkg::XLEN-1:0]          req_addr_i,
    input  logic [lsu_pkg::XLEN-1:0]          req_data_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]    req_rd_i,
    output logic                              credit_o,
    // memory side, req held until ack
    output logic                              mem_req_o,
    output logic                              mem_we_o,
    output logic [lsu_pkg::XLEN-1:0]          mem_addr_o,
    output logic [lsu_pkg::STRB_W-1:0]        mem_wstrb_o,
    output logic [lsu_pkg::XLEN-1:0]          mem_wdata_o,
    input  logic                              mem_ack_i,
    input  logic [lsu_pkg::XLEN-1:0]          mem_rdata_i,
    // writeback side, no back-pressure
    output logic                              rsp_valid_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]    rsp_rd_o,
    output logic [lsu_pkg::XLEN-1:0]          rsp_data_o,
    output logic                              rsp_fault_o
);

    // queue head
    logic                           head_valid;
    lsu_pkg::lsu_op_u               head_op;
    logic [lsu_pkg::XLEN-1:0]       head_addr;
    logic [lsu_pkg::XLEN-1:0]       head_data;
    logic [lsu_pkg::REG_ADDR_W-1:0] head_rd;
    logic                           pop;
    // datapath results
    logic [lsu_pkg::STRB_W-1:0]     store_wstrb;
    logic [lsu_pkg::XLEN-1:0]       store_wdata;
    logic [lsu_pkg::XLEN-1:0]       load_data;
    logic [lsu_pkg::XLEN-1:0]       old_word;
    logic [lsu_pkg::XLEN-1:0]       amo_new;

    lsu_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk          (clk),
        .rst          (rst),
        .push_i       (req_valid_i),
        .op_i         (req_op_i),
        .addr_i       (req_addr_i),
        .data_i       (req_data_i),
        .rd_i         (req_rd_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_op_o    (head_op),
        .head_addr_o  (head_addr),
        .head_data_o  (head_data),
        .head_rd_o    (head_rd),
        .credit_o     (credit_o)
    );

    lsu_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .head_valid_i  (head_valid),
        .head_op_i     (head_op),
        .head_addr_i   (head_addr),
        .head_data_i   (head_data),
        .head_rd_i     (head_rd),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i),
        .store_wstrb_i (store_wstrb),
        .store_wdata_i (store_wdata),
        .load_data_i   (load_data),
        .amo_new_i     (amo_new),
        .pop_o         (pop),
        .old_word_o    (old_word),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wstrb_o   (mem_wstrb_o),
        .mem_wdata_o   (mem_wdata_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_rd_o      (rsp_rd_o),
        .rsp_data_o    (rsp_data_o),
        .rsp_fault_o   (rsp_fault_o)
    );

    lsu_store_align i_store_align (
        .op_i     (head_op),
        .offset_i (head_addr[1:0]),
        .data_i   (head_data),
        .wstrb_o  (store_wstrb),
        .wdata_o  (store_wdata)
    );

    lsu_load_extract i_load_extract (
        .op_i     (head_op),
        .offset_i (head_addr[1:0]),
        .rdata_i  (mem_rdata_i),
        .data_o   (load_data)
    );

    lsu_amo_alu i_amo_alu (
        .func_i    (head_op.amo.func),
        .old_i     (old_word),
        .operand_i (head_data),
        .new_o     (amo_new)
    );

endmodule

/* bench/lsu_tb_ref.svh */
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

// shadow state, walked in request order
logic [31:0] shadow_mem [64];
logic        shadow_resv_valid;
logic [5:0]  shadow_resv_idx;

// expected response of one request, shadow state updated on the way
function automatic void ref_apply(input logic [6:0] op, input logic [31:0] addr,
                                  input logic [31:0] data, output logic [31:0] exp_data,
                                  output logic exp_fault);
    logic [2:0]  kind;
    logic [1:0]  size;
    logic [1:0]  off;
    logic [5:0]  idx;
    logic [31:0] word;
    logic [31:0] shifted;
    logic [31:0] upd;
    int          nbytes;
    kind = op[6:4];
    size = op[2:1];
    off = addr[1:0];
    idx = addr[7:2];
    word = shadow_mem[idx];
    shifted = word >> (8 * off);
    exp_data = '0;
    exp_fault = 1'b0;
    nbytes = (size == lsu_pkg::SIZE_BYTE) ? 1 : (size == lsu_pkg::SIZE_HALF) ? 2 : 4;
    // atomics at a non-zero offset fault; sc and amo still drop the reservation
    if (kind != lsu_pkg::KIND_LOAD && kind != lsu_pkg::KIND_STORE && off != 2'b00) begin
        exp_fault = 1'b1;
        if (kind != lsu_pkg::KIND_LR) shadow_resv_valid = 1'b0;
        return;
    end
    case (kind)
        lsu_pkg::KIND_LOAD: begin
            if (nbytes == 1) exp_data = op[3] ? {24'h0, shifted[7:0]}
                                              : {{24{shifted[7]}}, shifted[7:0]};
            else if (nbytes == 2) exp_data = op[3] ? {16'h0, shifted[15:0]}
                                                   : {{16{shifted[15]}}, shifted[15:0]};
            else exp_data = word;
        end
        lsu_pkg::KIND_STORE: begin
            for (int i = 0; i < 4; i++) begin
                if (i >= off && i < off + nbytes) word[8*i +: 8] = data[8*(i-off) +: 8];
            end
            shadow_mem[idx] = word;
            shadow_resv_valid = 1'b0;
        end
        lsu_pkg::KIND_LR: begin
            exp_data = word;
            shadow_resv_valid = 1'b1;
            shadow_resv_idx = idx;
        end
        lsu_pkg::KIND_SC: begin
            if (shadow_resv_valid && shadow_resv_idx == idx) shadow_mem[idx] = data;
            else exp_data = 32'd1;
            shadow_resv_valid = 1'b0;
        end
        default: begin
            // amo, old word back, new word stored
            case (op[3:0])
                lsu_pkg::AMO_ADD:  upd = word + data;
                lsu_pkg::AMO_XOR:  upd = word ^ data;
                lsu_pkg::AMO_AND:  upd = word & data;
                lsu_pkg::AMO_OR:   upd = word | data;
                lsu_pkg::AMO_MIN:  upd = ($signed(word) < $signed(data)) ? word : data;
                lsu_pkg::AMO_MAX:  upd = ($signed(word) > $signed(data)) ? word : data;
                lsu_pkg::AMO_MINU: upd = (word < data) ? word : data;
                lsu_pkg::AMO_MAXU: upd = (word > data) ? word : data;
                default:           upd = data;
            endcase
            exp_data = word;
            shadow_mem[idx] = upd;
            shadow_resv_valid = 1'b0;
        end
    endcase
endfunction

`endif

/* bench/lsu_tb.sv */
module lsu_tb;

    `include "lsu_tb_ref.svh"

    localparam int QUEUE_DEPTH = 4;
    localparam int N_OPS = 400;

    logic                clk;
    logic                rst;
    logic                req_valid_i;
    lsu_pkg::lsu_op_u    req_op_i;
    logic [31:0]         req_addr_i;
    logic [31:0]         req_data_i;
    logic [4:0]          req_rd_i;
    logic                credit_o;
    logic                mem_req_o;
    logic                mem_we_o;
    logic [31:0]         mem_addr_o;
    logic [3:0]          mem_wstrb_o;
    logic [31:0]         mem_wdata_o;
    logic                mem_ack_i;
    logic [31:0]         mem_rdata_i;
    logic                rsp_valid_o;
    logic [4:0]          rsp_rd_o;
    logic [31:0]         rsp_data_o;
    logic                rsp_fault_o;

    // memory model and bookkeeping
    logic [31:0] mem [64];
    logic        mem_pending;
    int          mem_wait;
    integer      seed;
    int          credits;
    int          credit_pulses;
    // responses as counted by the upstream
    int          retired;
    int          issued;
    int          rsp_count;
    int          errors;
    logic        follow_sc;
    logic [31:0] lr_addr;
    logic [31:0] exp_data_q [$];
    logic        exp_fault_q [$];
    logic [4:0]  exp_rd_q [$];

    lsu_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_rd_i    (req_rd_i),
        .credit_o    (credit_o),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wstrb_o (mem_wstrb_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rd_o    (rsp_rd_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_fault_o (rsp_fault_o)
    );

    always #20 clk = ~clk;

    // random request over 16 words with lr often followed by sc to the same word
    task automatic make_request(output logic [6:0] op, output logic [31:0] addr);
        logic [31:0] r;
        logic [2:0]  kind;
        logic [1:0]  size;
        r = $random(seed);
        size = (r[9:8] == 2'd3) ? lsu_pkg::SIZE_WORD : r[9:8];
        case (r[2:0])
            3'd0, 3'd1: kind = lsu_pkg::KIND_LOAD;
            3'd2, 3'd3: kind = lsu_pkg::KIND_STORE;
            3'd4:       kind = lsu_pkg::KIND_LR;
            3'd5:       kind = lsu_pkg::KIND_SC;
            default:    kind = lsu_pkg::KIND_AMO;
        endcase
        addr = {26'h0, r[13:10], 2'b00};
        if (kind == lsu_pkg::KIND_AMO) op = {kind, 4'(r[19:16] % 9)};
        else op = {kind, r[3], size, 1'b0};
        if (kind == lsu_pkg::KIND_LOAD || kind == lsu_pkg::KIND_STORE) begin
            // natural alignment for the size
            if (size == lsu_pkg::SIZE_BYTE) addr[1:0] = r[21:20];
            else if (size == lsu_pkg::SIZE_HALF) addr[1:0] = {r[21], 1'b0};
        end else if (r[23:22] == 2'd0) begin
            // one atomic in four lands off the word boundary
            addr[1:0] = r[25:24] | 2'b01;
        end
        if (follow_sc && r[26]) begin
            op = {lsu_pkg::KIND_SC, 4'h0};
            addr = lr_addr;
        end
        follow_sc = (kind == lsu_pkg::KIND_LR) && (op[6:4] == lsu_pkg::KIND_LR);
        lr_addr = addr;
    endtask

    // credits, memory model and stimulus on the falling edge
    always @(negedge clk) begin
        logic [6:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] e_data;
        logic        e_fault;
        if (!rst) begin
            if (credit_o) begin
                credits++;
                credit_pulses++;
            end
            if (rsp_valid_o) begin
                retired++;
            end
            // one cycle wide ack after 1 to 4 cycles
            if (mem_ack_i) begin
                mem_ack_i = 1'b0;
            end else if (mem_req_o) begin
                if (!mem_pending) begin
                    mem_pending = 1'b1;
                    mem_wait = 1 + ($random(seed) & 3);
                end
                mem_wait--;
                if (mem_wait == 0) begin
                    mem_pending = 1'b0;
                    mem_ack_i = 1'b1;
                    if (mem_addr_o[31:8] != 0 || mem_addr_o[1:0] != 0) begin
                        errors++;
                        $display("memory request to a bad address %08h", mem_addr_o);
                    end
                    // read data is the word before the write
                    mem_rdata_i = mem[mem_addr_o[7:2]];
                    for (int i = 0; i < 4; i++) begin
                        if (mem_we_o && mem_wstrb_o[i])
                            mem[mem_addr_o[7:2]][8*i +: 8] = mem_wdata_o[8*i +: 8];
                    end
                end
            end
            req_valid_i = 1'b0;
            if (issued < N_OPS && credits > 0 && $random(seed) & 1) begin
                make_request(op, addr);
                data = $random(seed);
                req_valid_i = 1'b1;
                req_op_i = op;
                req_addr_i = addr;
                req_data_i = data;
                req_rd_i = 5'(issued);
                ref_apply(op, addr, data, e_data, e_fault);
                exp_data_q.push_back(e_data);
                exp_fault_q.push_back(e_fault);
                exp_rd_q.push_back(5'(issued));
                credits--;
                issued++;
                // an early or extra credit lets too many requests in
                if (issued - retired > QUEUE_DEPTH) begin
                    errors++;
                    $display("more than %0d requests outstanding", QUEUE_DEPTH);
                end
            end
        end
    end

    // compare responses mid-cycle where outputs are settled
    always @(negedge clk) begin
        logic [31:0] e_data;
        logic        e_fault;
        logic [4:0]  e_rd;
        if (!rst && rsp_valid_o) begin
            rsp_count++;
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("response arrived with no request outstanding");
            end else begin
                e_data = exp_data_q.pop_front();
                e_fault = exp_fault_q.pop_front();
                e_rd = exp_rd_q.pop_front();
                // tag mismatch means out of order
                if (rsp_rd_o !== e_rd) begin
                    errors++;
                    $display("CHECK FAILED rsp_rd_o: expected %02h, got %02h", e_rd, rsp_rd_o);
                end
                if (rsp_data_o !== e_data) begin
                    errors++;
                    $display("CHECK FAILED rsp_data_o: expected %08h, got %08h",
                             e_data, rsp_data_o);
                end
                if (rsp_fault_o !== e_fault) begin
                    errors++;
                    $display("CHECK FAILED rsp_fault_o: expected %01h, got %01h",
                             e_fault, rsp_fault_o);
                end
            end
        end
    end

    initial begin
        seed = 32'h6491_3922;
        clk = 1'b0;
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_op_i = '0;
        req_addr_i = '0;
        req_data_i = '0;
        req_rd_i = '0;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        mem_pending = 1'b0;
        mem_wait = 0;
        credits = QUEUE_DEPTH;
        credit_pulses = 0;
        retired = 0;
        issued = 0;
        rsp_count = 0;
        errors = 0;
        follow_sc = 1'b0;
        lr_addr = '0;
        shadow_resv_valid = 1'b0;
        shadow_resv_idx = '0;
        // same fill in model and shadow
        for (int i = 0; i < 64; i++) begin
            mem[i] = (i + 1) * 32'h9E37_79B9;
            shadow_mem[i] = (i + 1) * 32'h9E37_79B9;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait (rsp_count == N_OPS);
        repeat (4) @(negedge clk);
        if (credit_pulses != N_OPS) begin
            errors++;
            $display("saw %0d credit pulses for %0d requests", credit_pulses, N_OPS);
        end
        $display("%0d errors in %0d responses", errors, rsp_count);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog allows 12 cycles per operation plus margin
    initial begin
        repeat (N_OPS * 12 + 200) @(posedge clk);
        $display("timeout with %0d of %0d responses received", rsp_count, N_OPS);
        $display("Regression failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+bench
verilog/lsu_pkg.sv
verilog/lsu_req_queue.sv
verilog/lsu_ctrl.sv
verilog/lsu_store_align.sv
verilog/lsu_load_extract.sv
verilog/lsu_amo_alu.sv
verilog/lsu_top.sv
bench/lsu_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb -f flist.f \
    --Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
